/* div_pkg.sv */
package div_pkg;

	////////////////////
	// Widths
	////////////////////

	// Default data width of the unit, which also sizes every struct below
	localparam int XLEN_DEFAULT = 32;

	// The destination tag is a register-file index
	localparam int TAG_W = 5;

	////////////////////
	// Operation encoding
	////////////////////

	// Values follow the low two bits of the M-extension funct3 for the divides
	// Bit 1 selects the remainder and bit 0 selects the unsigned form
	typedef enum logic [1:0] {
		OP_DIV  = 2'd0,
		OP_DIVU = 2'd1,
		OP_REM  = 2'd2,
		OP_REMU = 2'd3
	} div_op_e;

	////////////////////
	// Stage payloads
	////////////////////

	// Request as issued by the execute stage
	typedef struct packed {
		div_op_e                 op;
		logic [XLEN_DEFAULT-1:0] rs1;
		logic [XLEN_DEFAULT-1:0] rs2;
		logic [TAG_W-1:0]        tag;
	} div_req_t;

	// Unsigned operands and the sign rules that the result stage applies later
	typedef struct packed {
		logic [XLEN_DEFAULT-1:0] mag_a;
		logic [XLEN_DEFAULT-1:0] mag_b;
		logic                    neg_quo;
		logic                    neg_rem;
		logic                    want_rem;
		logic [TAG_W-1:0]        tag;
	} div_prep_t;

	// Unsigned quotient and remainder, flags carried through from the operand stage
	typedef struct packed {
		logic [XLEN_DEFAULT-1:0] quo;
		logic [XLEN_DEFAULT-1:0] rem;
		logic                    neg_quo;
		logic                    neg_rem;
		logic                    want_rem;
		logic [TAG_W-1:0]        tag;
	} div_raw_t;

	// Writeback value for the register file
	typedef struct packed {
		logic [XLEN_DEFAULT-1:0] result;
		logic [TAG_W-1:0]        tag;
	} div_rsp_t;

endpackage

/* div_operand_prep.sv */
module div_operand_prep #(
	parameter int XLEN = div_pkg::XLEN_DEFAULT
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_valid,
	input  div_pkg::div_req_t  i_req,
	output logic               o_valid,
	output div_pkg::div_prep_t o_prep
);
	import div_pkg::*;

	////////////////////
	// Decode
	////////////////////

	logic            is_signed;
	logic            is_rem;
	logic            sign_a;
	logic            sign_b;
	logic            b_zero;
	logic [XLEN-1:0] mag_a;
	logic [XLEN-1:0] mag_b;
	div_prep_t       prep_d;

	always_comb begin
		// DIV and REM treat both operands as two's complement
		is_signed = (i_req.op == OP_DIV) || (i_req.op == OP_REM);
		is_rem    = (i_req.op == OP_REM) || (i_req.op == OP_REMU);

		// A sign only counts for the signed operations
		sign_a = is_signed && i_req.rs1[XLEN-1];
		sign_b = is_signed && i_req.rs2[XLEN-1];
		b_zero = (i_req.rs2 == '0);

		// Negative operands are replaced by their negation
		// The most negative value maps onto itself, which reads correctly as unsigned
		mag_a = sign_a ? (~i_req.rs1 + 1'b1) : i_req.rs1;
		mag_b = sign_b ? (~i_req.rs2 + 1'b1) : i_req.rs2;
	end

	always_comb begin
		prep_d.mag_a = mag_a;
		prep_d.mag_b = mag_b;

		// The quotient is negative when the signs differ
		// A zero divisor keeps the all-ones quotient as it comes out of the array
		prep_d.neg_quo = (sign_a != sign_b) && !b_zero;

		// The remainder follows the sign of the dividend in every case
		prep_d.neg_rem = sign_a;

		prep_d.want_rem = is_rem;
		prep_d.tag      = i_req.tag;
	end

	////////////////////
	// Stage register
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	// Payload is captured every cycle and only read alongside o_valid
	always_ff @(posedge clk) begin
		o_prep <= prep_d;
	end

endmodule

/* div_array.sv */
module div_array #(
	parameter int                XLEN       = div_pkg::XLEN_DEFAULT,
	parameter logic [XLEN-1:0]   STAGE_LIST = '1
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_valid,
	input  div_pkg::div_prep_t i_prep,
	output logic               o_valid,
	output div_pkg::div_raw_t  o_raw
);
	import div_pkg::*;

	// Everything one step hands to the next
	// part holds the partial remainder in its top bits and the unused dividend bits below
	typedef struct packed {
		logic [XLEN-1:0]  part;
		logic [XLEN-1:0]  dvs;
		logic [XLEN-1:0]  quo;
		logic             neg_quo;
		logic             neg_rem;
		logic             want_rem;
		logic [TAG_W-1:0] tag;
	} step_t;

	// Entry i is the input of step i, entry XLEN is the array result
	step_t st  [XLEN+1];
	logic  vld [XLEN+1];

	////////////////////
	// Array input
	////////////////////

	assign vld[0]         = i_valid;
	assign st[0].part     = i_prep.mag_a;
	assign st[0].dvs      = i_prep.mag_b;
	assign st[0].quo      = '0;
	assign st[0].neg_quo  = i_prep.neg_quo;
	assign st[0].neg_rem  = i_prep.neg_rem;
	assign st[0].want_rem = i_prep.want_rem;
	assign st[0].tag      = i_prep.tag;

	////////////////////
	// Divide steps
	////////////////////

	// Step i decides quotient bit XLEN-1-i
	for (genvar i = 0; i < XLEN; i++) begin : g_step
		// The window grows by one bit each step
		localparam int W = i + 1;

		logic [W-1:0] win;
		logic [W-1:0] dvs_lo;
		logic [W-1:0] rest;
		logic         hi_set;
		logic         q_bit;
		step_t        nxt;

		// Top W bits are the partial remainder with the next dividend bit shifted in
		assign win    = st[i].part[XLEN-1 -: W];
		assign dvs_lo = st[i].dvs[W-1:0];

		// Any divisor bit at or above W makes it larger than the window
		assign hi_set = |(st[i].dvs >> W);

		// Restoring step, subtract only when the divisor fits
		assign q_bit = !hi_set && (win >= dvs_lo);
		assign rest  = q_bit ? (win - dvs_lo) : win;

		always_comb begin
			nxt = st[i];
			// The lower dividend bits stay where they are for the later steps
			nxt.part[XLEN-1 -: W] = rest;
			nxt.quo[XLEN-1-i]     = q_bit;
		end

		// Same bit order as the quotient, so the MSB of STAGE_LIST registers step 0
		if (STAGE_LIST[XLEN-1-i]) begin : g_reg
			step_t st_q;
			logic  vld_q;

			always_ff @(posedge clk) begin
				if (rst) begin
					vld_q <= 1'b0;
				end else begin
					vld_q <= vld[i];
				end
			end

			always_ff @(posedge clk) begin
				st_q <= nxt;
			end

			assign vld[i+1] = vld_q;
			assign st[i+1]  = st_q;
		end else begin : g_comb
			// Unregistered step chains straight into the next one
			assign vld[i+1] = vld[i];
			assign st[i+1]  = nxt;
		end
	end

	////////////////////
	// Array output
	////////////////////

	assign o_valid = vld[XLEN];

	// After the last step the whole part word is the remainder
	always_comb begin
		o_raw.quo      = st[XLEN].quo;
		o_raw.rem      = st[XLEN].part;
		o_raw.neg_quo  = st[XLEN].neg_quo;
		o_raw.neg_rem  = st[XLEN].neg_rem;
		o_raw.want_rem = st[XLEN].want_rem;
		o_raw.tag      = st[XLEN].tag;
	end

endmodule

/* div_result_fixup.sv */
module div_result_fixup #(
	parameter int XLEN = div_pkg::XLEN_DEFAULT
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_valid,
	input  div_pkg::div_raw_t i_raw,
	output logic              o_valid,
	output div_pkg::div_rsp_t o_rsp
);
	import div_pkg::*;

	////////////////////
	// Sign restore
	////////////////////

	logic [XLEN-1:0] quo_s;
	logic [XLEN-1:0] rem_s;
	div_rsp_t        rsp_d;

	// Two's-complement negation of the unsigned results
	// A zero-divisor quotient reaches here with neg_quo clear and stays all ones
	always_comb begin
		if (i_raw.neg_quo) begin
			quo_s = ~i_raw.quo + 1'b1;
		end else begin
			quo_s = i_raw.quo;
		end

		// A zero remainder negates to zero, so no exception is needed here
		if (i_raw.neg_rem) begin
			rem_s = ~i_raw.rem + 1'b1;
		end else begin
			rem_s = i_raw.rem;
		end
	end

	////////////////////
	// Result select
	////////////////////

	// REM and REMU write the remainder, DIV and DIVU the quotient
	always_comb begin
		if (i_raw.want_rem) begin
			rsp_d.result = rem_s;
		end else begin
			rsp_d.result = quo_s;
		end
		rsp_d.tag = i_raw.tag;
	end

	////////////////////
	// Stage register
	////////////////////

	// The strobe is high for one cycle per operation since nothing ever stalls
	always_ff @(posedge clk) begin
		if (rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	// Writeback value and tag, meaningful only while o_valid is high
	always_ff @(posedge clk) begin
		o_rsp <= rsp_d;
	end

endmodule

/* div_unit.sv */
module div_unit #(
	parameter int              XLEN       = div_pkg::XLEN_DEFAULT,
	parameter logic [XLEN-1:0] STAGE_LIST = '1
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_valid,
	input  div_pkg::div_req_t i_req,
	output logic              o_valid,
	output div_pkg::div_rsp_t o_rsp
);
	import div_pkg::*;

	// The payload structs are sized by the package width
	// so any other XLEN would break every connection below
	if (XLEN != XLEN_DEFAULT) begin : g_width_check
		$error("div_unit XLEN %0d differs from XLEN_DEFAULT %0d", XLEN, XLEN_DEFAULT);
	end

	////////////////////
	// Stage links
	////////////////////

	// Operand stage to divider array
	logic      p_valid;
	div_prep_t p_data;

	// Divider array to result stage
	logic      r_valid;
	div_raw_t  r_data;

	////////////////////
	// Pipeline
	////////////////////

	// One cycle, magnitudes and sign rules
	div_operand_prep #(
		.XLEN(XLEN)
	) prep_i (
		.clk     (clk),
		.rst     (rst),
		.i_valid (i_valid),
		.i_req   (i_req),
		.o_valid (p_valid),
		.o_prep  (p_data)
	);

	// One cycle for each set bit of STAGE_LIST
	div_array #(
		.XLEN       (XLEN),
		.STAGE_LIST (STAGE_LIST)
	) array_i (
		.clk     (clk),
		.rst     (rst),
		.i_valid (p_valid),
		.i_prep  (p_data),
		.o_valid (r_valid),
		.o_raw   (r_data)
	);

	// One cycle, signs restored and quotient or remainder chosen
	div_result_fixup #(
		.XLEN(XLEN)
	) fixup_i (
		.clk     (clk),
		.rst     (rst),
		.i_valid (r_valid),
		.i_raw   (r_data),
		.o_valid (o_valid),
		.o_rsp   (o_rsp)
	);

endmodule

/* div_unit_properties.sv */
module div_unit_properties #(
	parameter int              XLEN       = div_pkg::XLEN_DEFAULT,
	parameter logic [XLEN-1:0] STAGE_LIST = '1
) (
	input logic              clk,
	input logic              rst,
	input logic              i_valid,
	input logic              i_rsp_valid,
	input div_pkg::div_rsp_t i_rsp
);
	import div_pkg::*;

	// Cycles from a sampled request to the sampled response strobe
	// Operand stage and result stage add one each, the array one per registered step
	localparam int LAT = 2 + $countones(STAGE_LIST);

	// Counts clock edges since rst was last seen high, saturating at the latency
	// A value of LAT means no reset fell inside the last LAT edges
	int rst_age = 0;

	// Number of assertion failures so far, read by the testbench for its verdict
	int fail_count = 0;

	always @(posedge clk) begin
		if (rst) begin
			rst_age <= 0;
		end else if (rst_age < LAT) begin
			rst_age <= rst_age + 1;
		end
	end

	// Every valid register clears in reset, so no strobe can follow it
	a_reset_clears: assert property (@(posedge clk) rst |=> !i_rsp_valid)
		else begin
			$error("o_valid high in the cycle after reset");
			fail_count++;
		end

	// A request taken LAT edges ago with no reset since then must come out now
	a_fixed_latency: assert property (@(posedge clk)
		($past(i_valid && !rst, LAT) && (rst_age >= LAT)) |-> i_rsp_valid)
		else begin
			$error("no response %0d cycles after an accepted request", LAT);
			fail_count++;
		end

	// The writeback value must be fully known whenever it is strobed
	a_rsp_known: assert property (@(posedge clk) i_rsp_valid |-> !$isunknown(i_rsp))
		else begin
			$error("o_rsp has unknown bits while o_valid is high");
			fail_count++;
		end

endmodule

bind div_unit div_unit_properties #(
	.XLEN       (XLEN),
	.STAGE_LIST (STAGE_LIST)
) props_i (
	.clk         (clk),
	.rst         (rst),
	.i_valid     (i_valid),
	.i_rsp_valid (o_valid),
	.i_rsp       (o_rsp)
);

/* tb_div_unit.sv */
module tb_div_unit;
	import div_pkg::*;

	////////////////////
	// Run limits
	////////////////////

	localparam int NUM_TESTS   = 6;
	localparam int N_DIRECTED  = 46;
	localparam int N_RANDOM    = 400;
	localparam int N_RESET_RUN = 30;
	// One cycle per request, one pipeline drain per test, the rest covers gaps and reset
	localparam int CYCLE_LIMIT = N_DIRECTED + N_RANDOM + 2 * N_RESET_RUN
		+ 40 * NUM_TESTS + 500;

	logic     clk = 1'b0;
	logic     rst;
	logic     i_valid;
	div_req_t i_req;
	logic     o_valid;
	div_rsp_t o_rsp;

	// Expected responses in issue order
	div_rsp_t         exp_q[$];
	div_rsp_t         exp_rsp;
	logic [31:0]      rng_state;
	logic [TAG_W-1:0] tag_ctr;
	int               cycle_count = 0;
	int               err_count = 0;
	int               check_count = 0;
	int               tests_passed = 0;
	int               tests_failed = 0;

	div_unit div_unit_i (
		.clk     (clk),
		.rst     (rst),
		.i_valid (i_valid),
		.i_req   (i_req),
		.o_valid (o_valid),
		.o_rsp   (o_rsp)
	);

	always #50 clk = ~clk;

	////////////////////
	// Stimulus helpers
	////////////////////

	// 32-bit xorshift with the 13, 17, 5 shift triple
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Reference model built on the language's own division
	// Signed division truncates toward zero and the remainder takes the dividend's sign
	// The 64-bit width keeps the most negative value over minus one from overflowing
	function automatic div_rsp_t expected_rsp(input div_req_t req);
		logic signed [2*XLEN_DEFAULT-1:0] num;
		logic signed [2*XLEN_DEFAULT-1:0] den;
		logic signed [2*XLEN_DEFAULT-1:0] wide;
		div_rsp_t                         rsp;
		num     = {{XLEN_DEFAULT{req.rs1[XLEN_DEFAULT-1]}}, req.rs1};
		den     = {{XLEN_DEFAULT{req.rs2[XLEN_DEFAULT-1]}}, req.rs2};
		rsp.tag = req.tag;
		if (req.rs2 == '0) begin
			// A zero divisor gives an all-ones quotient and leaves the dividend as remainder
			rsp.result = (req.op == OP_DIV || req.op == OP_DIVU) ? '1 : req.rs1;
		end else begin
			case (req.op)
				OP_DIVU: rsp.result = req.rs1 / req.rs2;
				OP_REMU: rsp.result = req.rs1 % req.rs2;
				OP_DIV: begin
					wide       = num / den;
					rsp.result = wide[XLEN_DEFAULT-1:0];
				end
				default: begin
					wide       = num % den;
					rsp.result = wide[XLEN_DEFAULT-1:0];
				end
			endcase
		end
		return rsp;
	endfunction

	// Drives one request for the next rising edge and queues its expected response
	task automatic send_req(input div_op_e op, input logic [31:0] a,
		input logic [31:0] b, input logic [TAG_W-1:0] tag);
		div_req_t req;
		req.op  = op;
		req.rs1 = a;
		req.rs2 = b;
		req.tag = tag;
		@(negedge clk);
		i_valid = 1'b1;
		i_req   = req;
		exp_q.push_back(expected_rsp(req));
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			i_valid = 1'b0;
		end
	endtask

	// Sends the quotient and remainder forms of the same operands back to back
	task automatic send_pair(input div_op_e op_q, input div_op_e op_r,
		input logic [31:0] a, input logic [31:0] b);
		send_req(op_q, a, b, tag_ctr);
		tag_ctr++;
		send_req(op_r, a, b, tag_ctr);
		tag_ctr++;
	endtask

	// Random operations whose divisor or dividend is bent toward the corner cases
	task automatic send_random(input int count, input bit gaps);
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		for (int n = 0; n < count; n++) begin
			r = next_rand();
			a = next_rand();
			b = next_rand();
			case (r[6:4])
				3'd0: b = '0;
				3'd1: b = b >> r[12:8];
				3'd2: b = 32'hffff_ffff;
				3'd3: a = 32'h8000_0000;
				default: ;
			endcase
			send_req(div_op_e'(r[1:0]), a, b, r[17:13]);
			if (gaps && r[20:18] == 3'd0) begin
				idle(int'(r[22:21]) + 1);
			end
		end
	endtask

	// Waits until every queued response has come back, then reports the test
	task automatic finish_test(input string name, input int errs_before);
		idle(1);
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		if (err_count == errs_before) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, err_count - errs_before);
		end
	endtask

	////////////////////
	// Response check
	////////////////////

	// Registered outputs are read at the rising edge, before the new values land
	always @(posedge clk) begin
		if (o_valid && !rst) begin
			check_count++;
			assert (exp_q.size() != 0) else begin
				$display("response with tag %h arrived with no request outstanding", o_rsp.tag);
				err_count++;
			end
			if (exp_q.size() != 0) begin
				exp_rsp = exp_q.pop_front();
				assert (o_rsp.result == exp_rsp.result) else begin
					$display("mismatch o_rsp.result: got %h expected %h", o_rsp.result,
						exp_rsp.result);
					err_count++;
				end
				assert (o_rsp.tag == exp_rsp.tag) else begin
					$display("mismatch o_rsp.tag: got %h expected %h", o_rsp.tag, exp_rsp.tag);
					err_count++;
				end
			end
		end
	end

	// Hang guard
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d responses outstanding",
				cycle_count, exp_q.size());
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int errs;
		rst       = 1'b1;
		i_valid   = 1'b0;
		i_req     = '0;
		rng_state = 32'hce0a_4427;
		tag_ctr   = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// Small values, dividend below divisor, all ones and powers of two
		errs = err_count;
		send_pair(OP_DIVU, OP_REMU, 32'd7, 32'd2);
		send_pair(OP_DIVU, OP_REMU, 32'd100, 32'd7);
		send_pair(OP_DIVU, OP_REMU, 32'd3, 32'd10);
		send_pair(OP_DIVU, OP_REMU, 32'd0, 32'd5);
		send_pair(OP_DIVU, OP_REMU, 32'hffff_ffff, 32'd1);
		send_pair(OP_DIVU, OP_REMU, 32'hffff_ffff, 32'hffff_ffff);
		send_pair(OP_DIVU, OP_REMU, 32'hffff_ffff, 32'd3);
		send_pair(OP_DIVU, OP_REMU, 32'h8000_0000, 32'h0000_0010);
		send_pair(OP_DIVU, OP_REMU, 32'h0010_0000, 32'h0000_0010);
		send_pair(OP_DIVU, OP_REMU, 32'h1234_5678, 32'h0000_0100);
		finish_test("unsigned directed", errs);

		// All four sign combinations
		errs = err_count;
		send_pair(OP_DIV, OP_REM, 32'sd17, 32'sd5);
		send_pair(OP_DIV, OP_REM, -32'sd17, 32'sd5);
		send_pair(OP_DIV, OP_REM, 32'sd17, -32'sd5);
		send_pair(OP_DIV, OP_REM, -32'sd17, -32'sd5);
		send_pair(OP_DIV, OP_REM, -32'sd1, 32'sd2);
		send_pair(OP_DIV, OP_REM, 32'h7fff_ffff, -32'sd2);
		send_pair(OP_DIV, OP_REM, -32'sd7, -32'sd7);
		finish_test("signed directed", errs);

		errs = err_count;
		send_pair(OP_DIV, OP_REM, 32'd12345, 32'd0);
		send_pair(OP_DIVU, OP_REMU, 32'd12345, 32'd0);
		send_pair(OP_DIV, OP_REM, -32'sd9, 32'd0);
		send_pair(OP_DIVU, OP_REMU, -32'sd9, 32'd0);
		finish_test("divide by zero", errs);

		// Most negative value over minus one
		errs = err_count;
		send_pair(OP_DIV, OP_REM, 32'h8000_0000, 32'hffff_ffff);
		send_pair(OP_DIVU, OP_REMU, 32'h8000_0000, 32'hffff_ffff);
		finish_test("signed overflow", errs);

		errs = err_count;
		send_random(N_RANDOM, 1'b1);
		finish_test("random stream", errs);

		// Everything in flight is dropped, so the queue goes with it
		errs = err_count;
		send_random(N_RESET_RUN, 1'b0);
		@(negedge clk);
		i_valid = 1'b0;
		rst     = 1'b1;
		exp_q.delete();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		// Any strobe in this window finds an empty queue and is flagged
		idle(40);
		send_random(N_RESET_RUN, 1'b0);
		finish_test("reset during stream", errs);

		$display("tests passed %0d failed %0d, responses checked %0d, errors %0d, %s %0d",
			tests_passed, tests_failed, check_count, err_count, "assertion failures",
			div_unit_i.props_i.fail_count);
		if (tests_failed == 0 && err_count == 0 && div_unit_i.props_i.fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* tb.f */
div_pkg.sv
div_operand_prep.sv
div_array.sv
div_result_fixup.sv
div_unit.sv
div_unit_properties.sv
tb_div_unit.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_div_unit
FILELIST := tb.f

PASS_MSG := Simulation completed successfully

.PHONY: sim clean

# Builds the simulator, runs it, and fails unless the pass line shows up
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
